//--- project.f
+incdir+include
rtl/adam_pkg.sv
rtl/adam_srst_timer.sv
rtl/adam_pause_fsm.sv
rtl/adam_gpio_pads.sv
rtl/adam_periph_ctrl.sv
sim/tb_adam_periph_ctrl.sv

//--- Bender.yml
package:
  name: adam_periph_ctrl

export_include_dirs:
  - include

sources:
  - files:
      - rtl/adam_pkg.sv
      - rtl/adam_srst_timer.sv
      - rtl/adam_pause_fsm.sv
      - rtl/adam_gpio_pads.sv
      - rtl/adam_periph_ctrl.sv

  - target: simulation
    files:
      - sim/tb_adam_periph_ctrl.sv

//--- sim/tb_adam_periph_ctrl.sv
`timescale 1ns/10ps

`include "adam_defs.svh"

module tb_adam_periph_ctrl;

    import adam_pkg::*;

    localparam time CLK_HALF    = 20ns;
    localparam time DRIVE_DLY   = 5ns;  // inputs move this long after the rising edge.
    localparam int  REQ_TIMEOUT = 3;
    localparam int  ACK_TIMEOUT = 40;

    logic clk;
    logic rst_i;

    logic     pause_req_i;
    logic     pause_ack_o;
    mem_vec_t mem_srst_o;
    mem_vec_t mem_pause_req_o;
    mem_vec_t mem_pause_ack_i;

    logic      cfg_wr_i;
    logic      cfg_rd_i;
    cfg_addr_t cfg_addr_i;
    data_t     cfg_wdata_i;
    data_t     cfg_rdata_o;
    logic      cfg_rvalid_o;

    pin_vec_t  gpio_i;
    pin_vec_t  gpio_o;
    pin_vec_t  gpio_mode_o;
    pin_vec_t  gpio_otype_o;
    func_vec_t gpio_func_o;

    int unsigned errors = 0;
    int unsigned checks = 0;
    logic [31:0] lfsr_state = 32'h7389;

    // expected pad configuration as the register map defines it.
    logic      writes_enabled = 1'b0;
    pin_vec_t  exp_out   = '0;
    pin_vec_t  exp_mode  = '0;
    pin_vec_t  exp_otype = '0;
    func_vec_t exp_func  = '0;
    pin_vec_t  gpio_level = '0;

    adam_periph_ctrl adam_periph_ctrl_i (
        .clk             (clk),
        .rst_i           (rst_i),
        .pause_req_i     (pause_req_i),
        .pause_ack_o     (pause_ack_o),
        .mem_srst_o      (mem_srst_o),
        .mem_pause_req_o (mem_pause_req_o),
        .mem_pause_ack_i (mem_pause_ack_i),
        .cfg_wr_i        (cfg_wr_i),
        .cfg_rd_i        (cfg_rd_i),
        .cfg_addr_i      (cfg_addr_i),
        .cfg_wdata_i     (cfg_wdata_i),
        .cfg_rdata_o     (cfg_rdata_o),
        .cfg_rvalid_o    (cfg_rvalid_o),
        .gpio_i          (gpio_i),
        .gpio_o          (gpio_o),
        .gpio_mode_o     (gpio_mode_o),
        .gpio_otype_o    (gpio_otype_o),
        .gpio_func_o     (gpio_func_o)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // galois form of x^32 + x^22 + x^2 + x + 1 that steps once per bit.
    function automatic logic [31:0] rand_bits(input int unsigned n);
        logic [31:0] v;
        int unsigned k;
        v = '0;
        for (k = 0; k < n; k++) begin
            v = {v[30:0], lfsr_state[0]};
            if (lfsr_state[0]) begin
                lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
            end else begin
                lfsr_state = lfsr_state >> 1;
            end
        end
        return v;
    endfunction

    function automatic data_t expected_read(input cfg_addr_t addr);
        data_t v;
        case (addr)
            3'd0:    v = data_t'(exp_out);
            3'd1:    v = data_t'(exp_mode);
            3'd2:    v = data_t'(exp_otype);
            3'd3:    v = exp_func;
            3'd4:    v = data_t'(gpio_level);
            default: v = '0;
        endcase
        return v;
    endfunction

    task automatic finish_run();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    endtask

    task automatic abort_on_timeout(input string what);
        errors++;
        $display("timed out while waiting for %s", what);
        finish_run();
    endtask

    task automatic check_value(input string name, input data_t got, input data_t exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("ERROR: %s = 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_pads();
        check_value("gpio_o", data_t'(gpio_o), data_t'(exp_out));
        check_value("gpio_mode_o", data_t'(gpio_mode_o), data_t'(exp_mode));
        check_value("gpio_otype_o", data_t'(gpio_otype_o), data_t'(exp_otype));
        check_value("gpio_func_o", gpio_func_o, exp_func);
    endtask

    task automatic check_idle_outputs(input mem_vec_t srst_exp);
        check_value("mem_srst_o", data_t'(mem_srst_o), data_t'(srst_exp));
        check_value("mem_pause_req_o", data_t'(mem_pause_req_o), '0);
        check_value("pause_ack_o", data_t'(pause_ack_o), '0);
        check_value("cfg_rvalid_o", data_t'(cfg_rvalid_o), '0);
        check_pads();
    endtask

    task automatic write_reg(input cfg_addr_t addr, input data_t data);
        @(posedge clk);
        #DRIVE_DLY;
        cfg_wr_i    = 1'b1;
        cfg_addr_i  = addr;
        cfg_wdata_i = data;
        @(posedge clk);
        #DRIVE_DLY;
        cfg_wr_i = 1'b0;
        if (writes_enabled) begin
            case (addr)
                3'd0:    exp_out   = data[`ADAM_GPIO_WIDTH-1:0];
                3'd1:    exp_mode  = data[`ADAM_GPIO_WIDTH-1:0];
                3'd2:    exp_otype = data[`ADAM_GPIO_WIDTH-1:0];
                3'd3:    exp_func  = data;
                default: ;
            endcase
        end
        @(negedge clk);
        check_pads();
    endtask

    task automatic read_expect(input cfg_addr_t addr);
        data_t exp;
        exp = expected_read(addr);
        @(posedge clk);
        #DRIVE_DLY;
        cfg_rd_i   = 1'b1;
        cfg_addr_i = addr;
        @(posedge clk);
        #DRIVE_DLY;
        cfg_rd_i = 1'b0;
        @(negedge clk);
        check_value("cfg_rvalid_o", data_t'(cfg_rvalid_o), 32'd1);
        check_value($sformatf("cfg_rdata_o at %0d", addr), cfg_rdata_o, exp);
        @(negedge clk);
        check_value("cfg_rvalid_o", data_t'(cfg_rvalid_o), '0); // single pulse.
    endtask

    task automatic wait_mem_req(input mem_vec_t level);
        int unsigned n;
        n = 0;
        @(negedge clk);
        while (mem_pause_req_o !== level) begin
            n++;
            if (n > REQ_TIMEOUT) begin
                abort_on_timeout($sformatf("mem_pause_req_o to reach 0x%h", level));
            end
            @(negedge clk);
        end
    endtask

    task automatic wait_pause_ack(input logic level);
        int unsigned n;
        n = 0;
        @(negedge clk);
        while (pause_ack_o !== level) begin
            n++;
            if (n > ACK_TIMEOUT) begin
                abort_on_timeout($sformatf("pause_ack_o to become %0d", level));
            end
            @(negedge clk);
        end
        check_value("mem_pause_ack_i", data_t'(mem_pause_ack_i),
                    data_t'({`ADAM_NO_MEMS{level}}));
    endtask

    // each memory follows its pause request after its own random delay.
    initial begin : mem_models
        logic [2:0]               delay_left [`ADAM_NO_MEMS];
        logic [`ADAM_NO_MEMS-1:0] pending;
        int unsigned              m;
        mem_pause_ack_i = '0;
        pending = '0;
        forever begin
            @(posedge clk);
            #DRIVE_DLY;
            for (m = 0; m < `ADAM_NO_MEMS; m++) begin
                if (mem_pause_ack_i[m] == mem_pause_req_o[m]) begin
                    pending[m] = 1'b0;
                end else begin
                    if (!pending[m]) begin
                        pending[m]    = 1'b1;
                        delay_left[m] = 3'(rand_bits(3));
                    end
                    if (delay_left[m] == 3'd0) begin
                        mem_pause_ack_i[m] = mem_pause_req_o[m];
                        pending[m]         = 1'b0;
                    end else begin
                        delay_left[m] = delay_left[m] - 3'd1;
                    end
                end
            end
        end
    end

    ack_needs_all_mems: assert property (@(posedge clk) disable iff (rst_i)
        (pause_ack_o && (&mem_pause_req_o)) |-> (&mem_pause_ack_i))
    else begin
        errors++;
        $display("pause_ack_o was high before every memory had acknowledged");
    end

    ack_rises_after_all: assert property (@(posedge clk) disable iff (rst_i)
        $rose(pause_ack_o) |-> $past(&mem_pause_ack_i))
    else begin
        errors++;
        $display("pause_ack_o rose without every acknowledge seen high");
    end

    ack_falls_after_none: assert property (@(posedge clk) disable iff (rst_i)
        $fell(pause_ack_o) |-> ($past(mem_pause_ack_i) == '0))
    else begin
        errors++;
        $display("pause_ack_o fell while a memory still acknowledged");
    end

    req_moves_together: assert property (@(posedge clk) disable iff (rst_i)
        (mem_pause_req_o == '0) || (mem_pause_req_o == mem_vec_t'('1)))
    else begin
        errors++;
        $display("mem_pause_req_o bits did not move together");
    end

    rvalid_follows_rd: assert property (@(posedge clk) disable iff (rst_i)
        cfg_rvalid_o == $past(cfg_rd_i))
    else begin
        errors++;
        $display("cfg_rvalid_o did not follow cfg_rd_i by one cycle");
    end

    initial begin : stimulus
        int unsigned srst_len;
        int unsigned i;
        int unsigned a;
        pin_vec_t    gpio_prev;

        rst_i       = 1'b1;
        pause_req_i = 1'b0;
        cfg_wr_i    = 1'b0;
        cfg_rd_i    = 1'b0;
        cfg_addr_i  = '0;
        cfg_wdata_i = '0;
        gpio_i      = gpio_level;

        repeat (3) begin
            @(posedge clk);
            @(negedge clk);
            check_idle_outputs(mem_vec_t'('1));
        end
        @(posedge clk); // the fourth reset cycle.
        #DRIVE_DLY;
        rst_i = 1'b0;

        // count the cycles the soft reset stays up after the hard reset.
        srst_len = 0;
        @(negedge clk);
        while (mem_srst_o == mem_vec_t'('1)) begin
            srst_len++;
            if (srst_len > 4 * `ADAM_SRST_CYCLES) begin
                abort_on_timeout("mem_srst_o to fall");
            end
            @(negedge clk);
        end
        check_value("mem_srst_o high cycles", srst_len, `ADAM_SRST_CYCLES + 1);
        check_idle_outputs('0);
        writes_enabled = 1'b1;

        for (i = 0; i < 3; i++) begin
            for (a = 0; a < 4; a++) begin
                write_reg(cfg_addr_t'(a), rand_bits(32));
                read_expect(cfg_addr_t'(a));
            end
        end

        // addresses from 4 up take no writes.
        for (a = 4; a < 8; a++) begin
            write_reg(cfg_addr_t'(a), rand_bits(32));
        end

        for (i = 0; i < 3; i++) begin
            @(posedge clk);
            #DRIVE_DLY;
            pause_req_i = 1'b1;
            wait_mem_req(mem_vec_t'('1));
            wait_pause_ack(1'b1);

            writes_enabled = 1'b0;
            write_reg(cfg_addr_t'(i), rand_bits(32));
            for (a = 0; a < 4; a++) begin
                read_expect(cfg_addr_t'(a));
            end

            @(posedge clk);
            #DRIVE_DLY;
            pause_req_i = 1'b0;
            wait_mem_req('0);
            wait_pause_ack(1'b0);
            writes_enabled = 1'b1;
            write_reg(cfg_addr_t'(3 - i), rand_bits(32));
        end

        for (i = 0; i < 2; i++) begin
            gpio_prev  = gpio_level;
            gpio_level = pin_vec_t'(rand_bits(`ADAM_GPIO_WIDTH));
            @(posedge clk);
            #DRIVE_DLY;
            gpio_i     = gpio_level;
            cfg_addr_i = cfg_addr_t'(4);
            @(posedge clk);
            #DRIVE_DLY;
            cfg_rd_i = 1'b1; // sampled on the second edge after the change.
            @(posedge clk);
            @(negedge clk);
            check_value("cfg_rvalid_o", data_t'(cfg_rvalid_o), 32'd1);
            check_value("cfg_rdata_o at 4", cfg_rdata_o, data_t'(gpio_prev));
            @(posedge clk);
            #DRIVE_DLY;
            cfg_rd_i = 1'b0;
            @(negedge clk);
            check_value("cfg_rvalid_o", data_t'(cfg_rvalid_o), 32'd1);
            check_value("cfg_rdata_o at 4", cfg_rdata_o, data_t'(gpio_level));
            @(negedge clk);
            check_value("cfg_rvalid_o", data_t'(cfg_rvalid_o), '0);
        end

        for (a = 4; a < 8; a++) begin
            read_expect(cfg_addr_t'(a));
        end

        finish_run();
    end

endmodule

//--- rtl/adam_periph_ctrl.sv
`timescale 1ns/10ps

module adam_periph_ctrl (
    input  logic clk,
    input  logic rst_i,

    input  logic pause_req_i,
    output logic pause_ack_o,

    output adam_pkg::mem_vec_t mem_srst_o,
    output adam_pkg::mem_vec_t mem_pause_req_o,
    input  adam_pkg::mem_vec_t mem_pause_ack_i,

    input  logic                cfg_wr_i,
    input  logic                cfg_rd_i,
    input  adam_pkg::cfg_addr_t cfg_addr_i,
    input  adam_pkg::data_t     cfg_wdata_i,
    output adam_pkg::data_t     cfg_rdata_o,
    output logic                cfg_rvalid_o,

    input  adam_pkg::pin_vec_t  gpio_i,
    output adam_pkg::pin_vec_t  gpio_o,
    output adam_pkg::pin_vec_t  gpio_mode_o,
    output adam_pkg::pin_vec_t  gpio_otype_o,
    output adam_pkg::func_vec_t gpio_func_o
);

    logic srst_start;
    logic srst_done;

    logic periph_srst; // pad registers held clear while memories are in reset.
    logic cfg_en;

    adam_pause_fsm adam_pause_fsm (
        .clk             (clk),
        .rst_i           (rst_i),

        .pause_req_i     (pause_req_i),
        .pause_ack_o     (pause_ack_o),

        .mem_pause_req_o (mem_pause_req_o),
        .mem_pause_ack_i (mem_pause_ack_i),
        .mem_srst_o      (mem_srst_o),

        .srst_start_o    (srst_start),
        .srst_done_i     (srst_done),

        .periph_srst_o   (periph_srst),
        .cfg_en_o        (cfg_en)
    );

    adam_srst_timer adam_srst_timer (
        .clk     (clk),
        .rst_i   (rst_i),

        .start_i (srst_start),
        .done_o  (srst_done)
    );

    adam_gpio_pads adam_gpio_pads (
        .clk           (clk),
        .rst_i         (rst_i),

        .periph_srst_i (periph_srst),
        .cfg_en_i      (cfg_en),

        .cfg_wr_i      (cfg_wr_i),
        .cfg_rd_i      (cfg_rd_i),
        .cfg_addr_i    (cfg_addr_i),
        .cfg_wdata_i   (cfg_wdata_i),
        .cfg_rdata_o   (cfg_rdata_o),
        .cfg_rvalid_o  (cfg_rvalid_o),

        .gpio_i        (gpio_i),
        .gpio_o        (gpio_o),
        .gpio_mode_o   (gpio_mode_o),
        .gpio_otype_o  (gpio_otype_o),
        .gpio_func_o   (gpio_func_o)
    );

endmodule

//--- rtl/adam_gpio_pads.sv
`timescale 1ns/10ps

`include "adam_defs.svh"

module adam_gpio_pads (
    input  logic clk,
    input  logic rst_i,

    input  logic periph_srst_i,
    input  logic cfg_en_i,

    input  logic                cfg_wr_i,
    input  logic                cfg_rd_i,
    input  adam_pkg::cfg_addr_t cfg_addr_i,
    input  adam_pkg::data_t     cfg_wdata_i,
    output adam_pkg::data_t     cfg_rdata_o,
    output logic                cfg_rvalid_o,

    input  adam_pkg::pin_vec_t  gpio_i,
    output adam_pkg::pin_vec_t  gpio_o,
    output adam_pkg::pin_vec_t  gpio_mode_o,
    output adam_pkg::pin_vec_t  gpio_otype_o,
    output adam_pkg::func_vec_t gpio_func_o
);

    import adam_pkg::*;

    localparam cfg_addr_t ADDR_OUT   = 3'd0;
    localparam cfg_addr_t ADDR_MODE  = 3'd1;
    localparam cfg_addr_t ADDR_OTYPE = 3'd2;
    localparam cfg_addr_t ADDR_FUNC  = 3'd3;
    localparam cfg_addr_t ADDR_IN    = 3'd4;

    pin_vec_t  out_q;
    pin_vec_t  mode_q;
    pin_vec_t  otype_q;
    func_vec_t func_q;

    pin_vec_t in_meta;
    pin_vec_t in_sync;

    logic  wr_ok;
    data_t rd_mux;

    // writes are only accepted while the system runs.
    assign wr_ok = cfg_wr_i && cfg_en_i;

    always_ff @(posedge clk) begin
        if (rst_i || periph_srst_i) begin
            out_q   <= '0;
            mode_q  <= '0; // all pins come up as inputs.
            otype_q <= '0;
            func_q  <= '0;
        end else if (wr_ok) begin
            case (cfg_addr_i)
                ADDR_OUT:   out_q   <= cfg_wdata_i[`ADAM_GPIO_WIDTH-1:0];
                ADDR_MODE:  mode_q  <= cfg_wdata_i[`ADAM_GPIO_WIDTH-1:0];
                ADDR_OTYPE: otype_q <= cfg_wdata_i[`ADAM_GPIO_WIDTH-1:0];
                ADDR_FUNC:  func_q  <= cfg_wdata_i;
                default: ;
            endcase
        end
    end

    // two stage synchronizer on the pad inputs.
    always_ff @(posedge clk) begin
        in_meta <= gpio_i;
        in_sync <= in_meta;
    end

    always_comb begin
        case (cfg_addr_i)
            ADDR_OUT:   rd_mux = data_t'(out_q);
            ADDR_MODE:  rd_mux = data_t'(mode_q);
            ADDR_OTYPE: rd_mux = data_t'(otype_q);
            ADDR_FUNC:  rd_mux = func_q;
            ADDR_IN:    rd_mux = data_t'(in_sync);
            default:    rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            cfg_rvalid_o <= 1'b0;
        end else begin
            cfg_rvalid_o <= cfg_rd_i;
        end
    end

    // read data only moves on a read, so it holds between accesses.
    always_ff @(posedge clk) begin
        if (cfg_rd_i) begin
            cfg_rdata_o <= rd_mux;
        end
    end

    assign gpio_o       = out_q;
    assign gpio_mode_o  = mode_q;
    assign gpio_otype_o = otype_q;
    assign gpio_func_o  = func_q;

endmodule

//--- rtl/adam_pause_fsm.sv
`timescale 1ns/10ps

module adam_pause_fsm (
    input  logic clk,
    input  logic rst_i,

    input  logic              pause_req_i,
    output logic              pause_ack_o,

    output adam_pkg::mem_vec_t mem_pause_req_o,
    input  adam_pkg::mem_vec_t mem_pause_ack_i,
    output adam_pkg::mem_vec_t mem_srst_o,

    output logic srst_start_o,
    input  logic srst_done_i,

    output logic periph_srst_o,
    output logic cfg_en_o
);

    import adam_pkg::*;

    pause_state_t state;

    logic all_acked;
    logic none_acked;

    assign all_acked  = &mem_pause_ack_i;
    assign none_acked = ~|mem_pause_ack_i;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state           <= RESET;
            srst_start_o    <= 1'b1; // still set on the first cycle out of reset.
            mem_srst_o      <= '1;
            periph_srst_o   <= 1'b1;
            cfg_en_o        <= 1'b0;
            mem_pause_req_o <= '0;
            pause_ack_o     <= 1'b0;
        end else begin
            srst_start_o <= 1'b0;

            case (state)
                RESET: begin
                    if (srst_done_i) begin
                        state         <= RUN;
                        mem_srst_o    <= '0;
                        periph_srst_o <= 1'b0;
                        cfg_en_o      <= 1'b1;
                    end
                end

                RUN: begin
                    if (pause_req_i) begin
                        state           <= PAUSING;
                        mem_pause_req_o <= '1;
                        cfg_en_o        <= 1'b0;
                    end
                end

                PAUSING: begin
                    // a withdrawn request unwinds without ever acknowledging.
                    if (!pause_req_i) begin
                        state           <= RESUMING;
                        mem_pause_req_o <= '0;
                    end else if (all_acked) begin
                        state       <= PAUSED;
                        pause_ack_o <= 1'b1;
                    end
                end

                PAUSED: begin
                    if (!pause_req_i) begin
                        state           <= RESUMING;
                        mem_pause_req_o <= '0;
                    end
                end

                RESUMING: begin
                    if (none_acked) begin
                        state       <= RUN;
                        pause_ack_o <= 1'b0; // host sees the exchange close here.
                        cfg_en_o    <= 1'b1;
                    end
                end

                default: begin
                    state           <= RESET;
                    srst_start_o    <= 1'b1;
                    mem_srst_o      <= '1;
                    periph_srst_o   <= 1'b1;
                    cfg_en_o        <= 1'b0;
                    mem_pause_req_o <= '0;
                    pause_ack_o     <= 1'b0;
                end
            endcase
        end
    end

endmodule

//--- rtl/adam_srst_timer.sv
`timescale 1ns/10ps

`include "adam_defs.svh"

module adam_srst_timer (
    input  logic clk,
    input  logic rst_i,

    input  logic start_i,
    output logic done_o
);

    import adam_pkg::*;

    srst_cnt_t cnt;

    // a zero count means the timer is idle.
    always_ff @(posedge clk) begin
        if (rst_i) begin
            cnt <= '0;
        end else if (start_i) begin
            cnt <= srst_cnt_t'(`ADAM_SRST_CYCLES); // a new start always reloads.
        end else if (cnt != '0) begin
            cnt <= cnt - 1'b1;
        end
    end

    // the last loaded cycle lands exactly ADAM_SRST_CYCLES after the start.
    assign done_o = (cnt == srst_cnt_t'(1));

endmodule

//--- rtl/adam_pkg.sv
`include "adam_defs.svh"

package adam_pkg;

    // one bit per pad.
    typedef logic [`ADAM_GPIO_WIDTH-1:0] pin_vec_t;

    // pin i owns bits 2i+1 to 2i.
    typedef logic [`ADAM_FUNC_WIDTH*`ADAM_GPIO_WIDTH-1:0] func_vec_t;

    // one bit per memory port.
    typedef logic [`ADAM_NO_MEMS-1:0] mem_vec_t;

    typedef logic [`ADAM_DATA_WIDTH-1:0]     data_t;
    typedef logic [`ADAM_CFG_ADDR_WIDTH-1:0] cfg_addr_t;

    // wide enough to hold the full window length.
    typedef logic [$clog2(`ADAM_SRST_CYCLES+1)-1:0] srst_cnt_t;

    typedef enum logic [2:0] {
        RESET,    // memories held in soft reset.
        RUN,
        PAUSING,  // waiting for every memory to acknowledge.
        PAUSED,
        RESUMING  // waiting for every acknowledge to drop.
    } pause_state_t;

endpackage

//--- include/adam_defs.svh
`ifndef ADAM_DEFS_SVH
`define ADAM_DEFS_SVH

// pad configuration.
`define ADAM_GPIO_WIDTH 16
`define ADAM_FUNC_WIDTH 2

// memory ports under soft reset and pause control.
`define ADAM_NO_MEMS 5

// configuration access.
`define ADAM_DATA_WIDTH     32
`define ADAM_CFG_ADDR_WIDTH 3

// length of the soft reset window after a hard reset in clock cycles.
`define ADAM_SRST_CYCLES 8

`endif
